// File: compile.f
design/matmul_types_pkg.sv
design/matmul_ctrl_pkg.sv
design/operand_mem.sv
design/operand_skew.sv
design/mac_pe.sv
design/systolic_array.sv
design/matmul_sequencer.sv
design/matmul_top.sv
testbench/matmul_checker.sv
testbench/tb_matmul.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_matmul -f compile.f -o sim_matmul

output="$(./obj_dir/sim_matmul)"
echo "$output"

if grep -qx "ALL TESTS PASSED" <<< "$output"; then
  exit 0
else
  exit 1
fi

// File: testbench/tb_matmul.sv
`timescale 1ns/100ps

module tb_matmul
  import matmul_types_pkg::*;
  import matmul_ctrl_pkg::*;
();

  localparam int clk_period  = 10;
  localparam int random_runs = 20;
  localparam int total_runs  = 1 + random_runs + 2 + 2 + 2;
  // generous bound on one run, in cycles
  localparam int run_bound   = 4 * (mat_size + drain_cycles + mat_size);
  localparam int watchdog_ns = (total_runs + 1) * run_bound * clk_period;

  logic                     clk;
  logic                     reset;
  mem_write_t               host_wr;
  logic                     start;
  logic                     busy;
  result_row_t              result;
  logic                     done;
  logic                     model_push;
  lane_vec_t [mat_size-1:0] model_rows;
  logic                     test_end;
  int                       test_id;
  int                       error_count;
  int                       tests_run;
  int                       tests_failed;
  int                       local_errors;
  int                       seed;
  elem_t                    mat_a [mat_size][mat_size];
  elem_t                    mat_b [mat_size][mat_size];

  matmul_top u_matmul_top (
    .clk     (clk),
    .reset   (reset),
    .host_wr (host_wr),
    .start   (start),
    .busy    (busy),
    .result  (result),
    .done    (done)
  );

  matmul_checker u_matmul_checker (
    .clk          (clk),
    .reset        (reset),
    .result       (result),
    .done         (done),
    .busy         (busy),
    .model_push   (model_push),
    .model_rows   (model_rows),
    .test_end     (test_end),
    .test_id      (test_id),
    .error_count  (error_count),
    .tests_run    (tests_run),
    .tests_failed (tests_failed)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // operand and model helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic randomize_a();
    for (int i = 0; i < mat_size; i++) begin
      for (int k = 0; k < mat_size; k++) begin
        mat_a[i][k] = elem_t'($random(seed));
      end
    end
  endtask

  task automatic randomize_b();
    for (int k = 0; k < mat_size; k++) begin
      for (int j = 0; j < mat_size; j++) begin
        mat_b[k][j] = elem_t'($random(seed));
      end
    end
  endtask

  task automatic set_identity_a();
    for (int i = 0; i < mat_size; i++) begin
      for (int k = 0; k < mat_size; k++) begin
        mat_a[i][k] = (i == k) ? elem_t'(1) : elem_t'(0);
      end
    end
  endtask

  // A goes in one column per address
  task automatic load_a();
    for (int k = 0; k < mat_size; k++) begin
      @(negedge clk);
      host_wr = '0;
      host_wr.we_a = 1'b1;
      host_wr.addr = addr_t'(k);
      for (int i = 0; i < mat_size; i++) begin
        host_wr.data[i] = mat_a[i][k];
      end
    end
    @(negedge clk);
    host_wr = '0;
  endtask

  // B goes in one row per address
  task automatic load_b();
    for (int k = 0; k < mat_size; k++) begin
      @(negedge clk);
      host_wr = '0;
      host_wr.we_b = 1'b1;
      host_wr.addr = addr_t'(k);
      for (int j = 0; j < mat_size; j++) begin
        host_wr.data[j] = mat_b[k][j];
      end
    end
    @(negedge clk);
    host_wr = '0;
  endtask

  // exact signed sum of A[i][k]*B[k][j], then reduced modulo 2^16
  task automatic compute_model();
    longint sum;
    for (int i = 0; i < mat_size; i++) begin
      for (int j = 0; j < mat_size; j++) begin
        sum = 0;
        for (int k = 0; k < mat_size; k++) begin
          sum += longint'($signed(mat_a[i][k])) * longint'($signed(mat_b[k][j]));
        end
        model_rows[i][j] = elem_t'(sum);
      end
    end
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!done && cycles < run_bound);
    if (!done) begin
      $display("ERROR at %0t: no done within %0d cycles of start", $time, run_bound);
      local_errors++;
    end
  endtask

  task automatic run_matmul(input bit extra_start);
    compute_model();
    @(negedge clk);
    model_push = 1'b1;
    start      = 1'b1;
    @(negedge clk);
    model_push = 1'b0;
    start      = 1'b0;
    // a second start in mid-run must not be accepted
    if (extra_start) begin
      repeat (3) @(negedge clk);
      if (!busy) begin
        $display("ERROR at %0t: busy low while the run should be active", $time);
        local_errors++;
      end
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
    wait_done();
  endtask

  task automatic end_test();
    repeat (2) @(negedge clk);
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed         = 32'hbede7459;
    local_errors = 0;
    reset        = 1'b1;
    start        = 1'b0;
    host_wr      = '0;
    model_push   = 1'b0;
    model_rows   = '0;
    test_end     = 1'b0;
    test_id      = 0;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    // nothing may move without a start
    test_id = 1;
    repeat (8) @(negedge clk);
    end_test();

    test_id = 2;
    set_identity_a();
    randomize_b();
    load_a();
    load_b();
    run_matmul(1'b0);
    end_test();

    test_id = 3;
    repeat (random_runs) begin
      randomize_a();
      randomize_b();
      load_a();
      load_b();
      run_matmul(1'b0);
    end
    end_test();

    test_id = 4;
    randomize_a();
    randomize_b();
    load_a();
    load_b();
    run_matmul(1'b1);
    run_matmul(1'b0);
    end_test();

    // new operands right after done
    test_id = 5;
    randomize_a();
    randomize_b();
    load_a();
    load_b();
    run_matmul(1'b0);
    randomize_a();
    randomize_b();
    load_a();
    load_b();
    run_matmul(1'b0);
    end_test();

    // memory A keeps its contents
    test_id = 6;
    randomize_a();
    randomize_b();
    load_a();
    load_b();
    run_matmul(1'b0);
    randomize_b();
    load_b();
    run_matmul(1'b0);
    end_test();

    repeat (2) @(negedge clk);
    $display("%0d tests, %0d failed, %0d checker errors, %0d other errors",
             tests_run, tests_failed, error_count, local_errors);
    if (tests_failed == 0 && error_count == 0 && local_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/matmul_checker.sv
`timescale 1ns/100ps

module matmul_checker
  import matmul_types_pkg::*;
  import matmul_ctrl_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  result_row_t              result,
  input  logic                     done,
  input  logic                     busy,
  input  logic                     model_push,
  input  lane_vec_t [mat_size-1:0] model_rows,
  input  logic                     test_end,
  input  int                       test_id,
  output int                       error_count,
  output int                       tests_run,
  output int                       tests_failed
);

  // expected C of each accepted start, oldest first
  lane_vec_t [mat_size-1:0] pending_q [$];
  int                       row_idx;
  int                       test_errors;
  int                       test_runs;

  initial begin
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    row_idx      = 0;
    test_errors  = 0;
    test_runs    = 0;
  end

  function automatic string test_name(input int id);
    case (id)
      1: return "idle after reset";
      2: return "identity times random";
      3: return "random products";
      4: return "start while busy";
      5: return "back to back";
      6: return "rewrite B only";
      default: return "unnamed";
    endcase
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    error_count++;
    test_errors++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // result stream monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!reset) begin
      if (model_push) begin
        pending_q.push_back(model_rows);
      end
      if (busy && pending_q.size() == 0) begin
        report_error("busy is high with no accepted start");
      end
      if (result.valid) begin
        if (pending_q.size() == 0) begin
          report_error("result row with no run in progress");
        end else if (row_idx >= mat_size) begin
          report_error($sformatf("more than %0d rows in one run", mat_size));
        end else if (result.data !== pending_q[0][row_idx]) begin
          $display("MISMATCH at %0t: result.data row %0d expected %h actual %h",
                   $time, row_idx, pending_q[0][row_idx], result.data);
          error_count++;
          test_errors++;
        end
        row_idx++;
      end
      if (done) begin
        if (pending_q.size() == 0) begin
          report_error("done with no run in progress");
        end else begin
          if (row_idx != mat_size) begin
            report_error($sformatf("done after %0d rows instead of %0d", row_idx, mat_size));
          end
          void'(pending_q.pop_front());
          test_runs++;
        end
        row_idx = 0;
      end
      // one line per finished test
      if (test_end) begin
        $display("test %0d %s: %0d runs, %0d errors",
                 test_id, test_name(test_id), test_runs, test_errors);
        tests_run++;
        if (test_errors != 0 || pending_q.size() != 0) begin
          tests_failed++;
        end
        test_errors = 0;
        test_runs   = 0;
      end
    end
  end

endmodule

// File: design/matmul_top.sv
`timescale 1ns/100ps

module matmul_top
  import matmul_types_pkg::*;
  import matmul_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  mem_write_t  host_wr,
  input  logic        start,
  output logic        busy,
  output result_row_t result,
  output logic        done
);

  addr_t     rd_addr;
  lane_vec_t a_rd_data;
  lane_vec_t b_rd_data;
  lane_vec_t a_skewed;
  lane_vec_t b_skewed;
  logic      feed;
  logic      clear;
  logic      capture;
  logic      shift;

  ////////////////////////////////////////////////////////////////////////////
  // operand memories and skew lines
  ////////////////////////////////////////////////////////////////////////////

  operand_mem u_mem_a (
    .clk     (clk),
    .reset   (reset),
    .we      (host_wr.we_a),
    .wr_addr (host_wr.addr),
    .wr_data (host_wr.data),
    .rd_addr (rd_addr),
    .rd_data (a_rd_data)
  );

  operand_mem u_mem_b (
    .clk     (clk),
    .reset   (reset),
    .we      (host_wr.we_b),
    .wr_addr (host_wr.addr),
    .wr_data (host_wr.data),
    .rd_addr (rd_addr),
    .rd_data (b_rd_data)
  );

  operand_skew u_skew_a (
    .clk       (clk),
    .reset     (reset),
    .clear     (clear),
    .feed      (feed),
    .lanes_in  (a_rd_data),
    .lanes_out (a_skewed)
  );

  operand_skew u_skew_b (
    .clk       (clk),
    .reset     (reset),
    .clear     (clear),
    .feed      (feed),
    .lanes_in  (b_rd_data),
    .lanes_out (b_skewed)
  );

  ////////////////////////////////////////////////////////////////////////////
  // compute grid and control
  ////////////////////////////////////////////////////////////////////////////

  // A enters from the left, B from the top
  systolic_array u_systolic_array (
    .clk     (clk),
    .reset   (reset),
    .clear   (clear),
    .capture (capture),
    .shift   (shift),
    .left_in (a_skewed),
    .top_in  (b_skewed),
    .row_out (result.data)
  );

  matmul_sequencer u_matmul_sequencer (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .rd_addr   (rd_addr),
    .feed      (feed),
    .clear     (clear),
    .capture   (capture),
    .shift     (shift),
    .row_valid (result.valid),
    .busy      (busy),
    .done      (done)
  );

endmodule

// File: design/matmul_sequencer.sv
`timescale 1ns/100ps

module matmul_sequencer
  import matmul_types_pkg::*;
  import matmul_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  start,
  output addr_t rd_addr,
  output logic  feed,
  output logic  clear,
  output logic  capture,
  output logic  shift,
  output logic  row_valid,
  output logic  busy,
  output logic  done
);

  // wide enough for the longest phase, the drain
  localparam int cnt_width = $clog2(drain_cycles);

  seq_state_t           state;
  logic [cnt_width-1:0] cnt;
  logic                 last_feed;
  logic                 last_drain;
  logic                 last_row;

  assign last_feed  = (cnt == cnt_width'(mat_size - 1));
  assign last_drain = (cnt == cnt_width'(drain_cycles - 1));
  assign last_row   = (cnt == cnt_width'(mat_size - 1));

  ////////////////////////////////////////////////////////////////////////////
  // phase FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= seq_idle;
      cnt   <= '0;
      clear <= 1'b0;
      done  <= 1'b0;
    end else begin
      clear <= 1'b0;
      done  <= 1'b0;
      case (state)
        seq_idle: begin
          if (start) begin
            state <= seq_feed;
            cnt   <= '0;
            clear <= 1'b1;
          end
        end
        seq_feed: begin
          if (last_feed) begin
            state <= seq_drain;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        seq_drain: begin
          if (last_drain) begin
            state <= seq_emit;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        seq_emit: begin
          if (last_row) begin
            state <= seq_idle;
            cnt   <= '0;
            done  <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= seq_idle;
      endcase
    end
  end

  // address k during the k-th feed cycle
  assign rd_addr   = addr_t'(cnt);
  assign feed      = (state == seq_feed);
  assign busy      = (state != seq_idle);
  assign row_valid = (state == seq_emit);

  // last accumulator settles in the final drain cycle
  assign capture = (state == seq_drain) && last_drain;
  // move the next row to the head, none after the last one
  assign shift   = (state == seq_emit) && !last_row;

  a_valid_done_excl: assert property (
    @(posedge clk) disable iff (reset) !(row_valid && done)
  );

  a_state_legal: assert property (
    @(posedge clk) disable iff (reset)
      state inside {seq_idle, seq_feed, seq_drain, seq_emit}
  );

endmodule

// File: design/systolic_array.sv
`timescale 1ns/100ps

module systolic_array
  import matmul_types_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      clear,
  input  logic      capture,
  input  logic      shift,
  input  lane_vec_t left_in,
  input  lane_vec_t top_in,
  output lane_vec_t row_out
);

  // registered outputs of each element toward its neighbors
  elem_t     a_fwd    [mat_size][mat_size];
  elem_t     b_fwd    [mat_size][mat_size];
  elem_t     acc_grid [mat_size][mat_size];
  lane_vec_t row_sr   [mat_size];

  ////////////////////////////////////////////////////////////////////////////
  // element grid
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < mat_size; i++) begin : g_row
    for (genvar j = 0; j < mat_size; j++) begin : g_col
      elem_t a_in;
      elem_t b_in;

      // edge elements take the skewed operands
      assign a_in = (j == 0) ? left_in[i] : a_fwd[i][(j == 0) ? 0 : j-1];
      assign b_in = (i == 0) ? top_in[j]  : b_fwd[(i == 0) ? 0 : i-1][j];

      mac_pe u_pe (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .in_a  (a_in),
        .in_b  (b_in),
        .out_a (a_fwd[i][j]),
        .out_b (b_fwd[i][j]),
        .acc   (acc_grid[i][j])
      );
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // result rows, head at index 0
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (capture) begin
      for (int i = 0; i < mat_size; i++) begin
        for (int j = 0; j < mat_size; j++) begin
          row_sr[i][j] <= acc_grid[i][j];
        end
      end
    end else if (shift) begin
      for (int i = 0; i < mat_size - 1; i++) begin
        row_sr[i] <= row_sr[i+1];
      end
      row_sr[mat_size-1] <= '0;
    end
  end

  assign row_out = row_sr[0];

  // the sequencer must never load and advance the rows at once
  a_capture_shift_excl: assert property (
    @(posedge clk) disable iff (reset) !(capture && shift)
  );

endmodule

// File: design/mac_pe.sv
`timescale 1ns/100ps

module mac_pe
  import matmul_types_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  clear,
  input  elem_t in_a,
  input  elem_t in_b,
  output elem_t out_a,
  output elem_t out_b,
  output elem_t acc
);

  elem_t product;

  // low half of the product is the same for signed and unsigned operands
  assign product = in_a * in_b;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
      acc   <= '0;
    end else begin
      // a travels right, b travels down
      out_a <= in_a;
      out_b <= in_b;
      if (clear) begin
        acc <= '0;
      end else begin
        acc <= acc + product;
      end
    end
  end

endmodule

// File: design/operand_skew.sv
`timescale 1ns/100ps

module operand_skew
  import matmul_types_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      clear,
  input  logic      feed,
  input  lane_vec_t lanes_in,
  output lane_vec_t lanes_out
);

  logic      feed_d;
  lane_vec_t masked;

  // feed is issued with the address, data comes a cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      feed_d <= 1'b0;
    end else begin
      feed_d <= feed;
    end
  end

  // stale memory output must not reach the grid
  assign masked = feed_d ? lanes_in : '0;

  for (genvar i = 0; i < mat_size; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign lanes_out[i] = masked[i];
    end else begin : g_delay
      elem_t pipe [i];

      always_ff @(posedge clk) begin
        if (reset || clear) begin
          for (int s = 0; s < i; s++) begin
            pipe[s] <= '0;
          end
        end else begin
          pipe[0] <= masked[i];
          for (int s = 1; s < i; s++) begin
            pipe[s] <= pipe[s-1];
          end
        end
      end

      assign lanes_out[i] = pipe[i-1];
    end
  end

endmodule

// File: design/operand_mem.sv
`timescale 1ns/100ps

module operand_mem
  import matmul_types_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      we,
  input  addr_t     wr_addr,
  input  lane_vec_t wr_data,
  input  addr_t     rd_addr,
  output lane_vec_t rd_data
);

  lane_vec_t mem [mat_size];

  // host side
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, a colliding write shows up one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: design/matmul_ctrl_pkg.sv
package matmul_ctrl_pkg;

  import matmul_types_pkg::*;

  // host write, A takes a column per address and B a row per address
  typedef struct packed {
    logic      we_a;
    logic      we_b;
    addr_t     addr;
    lane_vec_t data;
  } mem_write_t;

  // one row of C, strobed
  typedef struct packed {
    logic      valid;
    lane_vec_t data;
  } result_row_t;

  typedef enum logic [1:0] {
    seq_idle,
    seq_feed,
    seq_drain,
    seq_emit
  } seq_state_t;

  // skew plus grid traversal, then memory and MAC latency
  localparam int drain_cycles = 2 * (mat_size - 1) + 2;

endpackage

// File: design/matmul_types_pkg.sv
package matmul_types_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // datapath sizing
  ////////////////////////////////////////////////////////////////////////////

  // element width, two's complement
  localparam int data_width = 16;

  // lanes per edge, also rows and columns of every matrix
  localparam int mat_size = 4;

  // operands sit at addresses 0 .. mat_size-1
  localparam int addr_width = $clog2(mat_size);

  ////////////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [data_width-1:0] elem_t;
  typedef logic [addr_width-1:0] addr_t;

  // one row or column, lane 0 in the low bits
  typedef elem_t [mat_size-1:0] lane_vec_t;

endpackage
